// File: verification/exec_stimulus.txt
# fu uop opr_a opr_b opr_c rd trap | exp_a b_ld exp_b exp_uop (all hex)
# fu is one-hot {alu,lsu,cfu,csr}; b_ld 0 means operand B keeps its last loaded value
8 09 00001234 00000010 00000000 01 0 00001244 0 00000000 09
8 08 00000005 00000007 00000000 02 0 fffffffe 0 00000000 08
8 0c f0f0f0f0 ff00ff00 00000000 03 0 0ff00ff0 0 00000000 0c
8 0a f0f0f0f0 0f0f0000 00000000 04 0 fffff0f0 0 00000000 0a
8 0e f0f0f0f0 ff00ff00 00000000 05 0 f000f000 0 00000000 0e
8 11 00000001 00000024 00000000 06 0 00000010 0 00000000 11
8 12 80000000 0000001f 00000000 07 0 00000001 0 00000000 12
8 14 80000000 00000004 00000000 08 0 f8000000 0 00000000 14
8 16 12345678 00000008 00000000 09 0 78123456 0 00000000 16
8 01 ffffffff 00000001 00000000 0a 0 00000001 0 00000000 01
8 02 ffffffff 00000001 00000000 0b 0 00000000 0 00000000 02
8 01 00000001 ffffffff 00000000 0c 0 00000000 0 00000000 01
4 02 00001000 00000024 deadbeef 0d 0 00001024 0 00000000 02
4 12 00002000 fffffffc cafef00d 0e 0 00001ffc 1 cafef00d 12
1 03 00000300 11111111 0000abcd 0f 0 00000300 1 0000abcd 03
4 00 00000010 00000004 12345678 10 0 00000014 0 00000000 00
2 01 00000005 00000005 00000101 11 0 00000100 0 00000000 19
2 01 00000005 00000006 00000200 12 0 00000200 0 00000000 18
2 06 00000005 00000006 00000204 13 0 00000204 0 00000000 19
2 04 fffffff0 00000001 00000301 14 0 00000300 0 00000000 19
2 05 fffffff0 00000001 00000400 15 0 00000400 0 00000000 18
2 02 00000001 fffffff0 00000500 16 0 00000500 0 00000000 19
2 03 00000001 fffffff0 00000600 17 0 00000600 0 00000000 18
2 11 00000000 00000000 00000803 18 0 00000802 0 00000000 11
2 12 00001001 00000010 00000000 19 0 00001010 0 00000000 12
2 14 00000000 00000000 00000fff 1a 0 00000ffe 0 00000000 14
8 09 ffffffff 00000001 00000000 1f 1 00000000 0 00000000 09
4 10 00000100 00000004 00000055 00 0 00000104 1 00000055 10

// File: src.f
+incdir+hdl
hdl/exec_pkg.sv
hdl/exec_alu.sv
hdl/exec_branch_unit.sv
hdl/exec_result_mux.sv
hdl/exec_pipe_reg.sv
hdl/exec_stage.sv
verification/exec_stage_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the execute stage testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f src.f --top-module exec_stage_tb -o exec_stage_tb_sim || exit 1
sim_out="$(./obj_dir/exec_stage_tb_sim)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qF '=== PASS ===' && exit 0 || exit 1

// File: verification/exec_stage_tb.sv
/*
 * Execute stage testbench
 * Replays instruction vectors from a file under random back-pressure and flush
 * pulses, checks registered results, forwarding and the valid / busy handshake
 */
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_stage_tb;

    typedef struct packed {
        exec_pkg::fu_t   fu;
        exec_pkg::uop_t  uop;
        exec_pkg::word_t opr_a;
        exec_pkg::word_t opr_b;
        exec_pkg::word_t opr_c;
        logic [4:0]      rd;
        logic            trap;
        logic [1:0]      size;
        logic [31:0]     instr;
        exec_pkg::word_t exp_a;                 // Expected s3 operand A
        logic            b_ld;                  // B register loads
        exec_pkg::word_t exp_b;
        exec_pkg::uop_t  exp_uop;               // Resolved micro-op
    } vec_t;

    typedef struct packed {
        exec_pkg::ex_ctrl_t ctrl;
        exec_pkg::word_t    opr_a;
        exec_pkg::word_t    opr_b;
    } s3_out_t;

    logic               g_clk;
    logic               g_resetn;
    exec_pkg::ex_in_t   i_s2;
    logic               i_s2_valid;
    logic               i_flush;
    logic               i_s3_busy;
    logic               o_s2_busy;
    exec_pkg::ex_ctrl_t o_s3_ctrl;
    exec_pkg::word_t    o_s3_opr_a;
    exec_pkg::word_t    o_s3_opr_b;
    logic               o_s3_valid;
    exec_pkg::fwd_t     o_fwd;

    vec_t            vecs [64];
    int              n_vec;
    s3_out_t         exp_q [$];                 // Accepted, not yet taken
    exec_pkg::word_t model_b;                   // Last value loaded into B
    int              vec_idx;
    int              flush_mark;
    int              cycles;
    int              cycle_limit;
    logic [31:0]     lcg_state;

    exec_stage dut0 (
        .g_clk      (g_clk),      .g_resetn   (g_resetn),   .i_s2       (i_s2),
        .i_s2_valid (i_s2_valid), .i_flush    (i_flush),    .i_s3_busy  (i_s3_busy),
        .o_s2_busy  (o_s2_busy),  .o_s3_ctrl  (o_s3_ctrl),  .o_s3_opr_a (o_s3_opr_a),
        .o_s3_opr_b (o_s3_opr_b), .o_s3_valid (o_s3_valid), .o_fwd      (o_fwd)
    );

    initial begin
        g_clk = 1'b0;
        forever #20 g_clk = ~g_clk;             // 40 ns period
    end

    always @(posedge g_clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            abort_run($sformatf("timeout: run did not finish in %0d cycles", cycle_limit));
        end
    end

    // Reporting ------------------
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string what);
        abort_run($sformatf("mismatch at %0t ns: %s", $time, what));
    endtask

    task automatic compare_word(input exec_pkg::word_t got, input exec_pkg::word_t exp,
                                input string what);
        if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic compare_ctrl(input exec_pkg::ex_ctrl_t got, input exec_pkg::ex_ctrl_t exp,
                                input string what);
        if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic compare_fwd(input exec_pkg::fwd_t got, input exec_pkg::fwd_t exp,
                               input string what);
        if (got !== exp) report_mismatch($sformatf("%s got %h expected %h", what, got, exp));
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) report_mismatch($sformatf("%s got %b expected %b", what, got, exp));
    endtask

    // Stimulus and expectations ---
    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic load_vectors();
        int          fd;
        int          n;
        string       line;
        vec_t        v;
        logic [3:0]  fu;
        logic [4:0]  uop;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [4:0]  rd;
        logic        trap;
        logic [31:0] ea;
        logic        bld;
        logic [31:0] eb;
        logic [4:0]  eu;
        fd = $fopen("verification/exec_stimulus.txt", "r");
        if (fd == 0) abort_run("cannot open verification/exec_stimulus.txt");
        n_vec = 0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() == 0 || line.getc(0) == "#") continue;     // Column notes
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h",
                        fu, uop, a, b, c, rd, trap, ea, bld, eb, eu);
            if (n == 11 && n_vec < 64) begin
                v       = '{fu: fu, uop: uop, opr_a: a, opr_b: b, opr_c: c, rd: rd,
                            trap: trap, size: 2'(n_vec), instr: 32'h33 | (32'(n_vec) << 7),
                            exp_a: ea, b_ld: bld, exp_b: eb, exp_uop: eu};
                vecs[n_vec] = v;
                n_vec       = n_vec + 1;
            end
        end
        $fclose(fd);
        if (n_vec == 0) abort_run("no vectors found in the stimulus file");
    endtask

    function automatic exec_pkg::ex_in_t make_input(input int idx);
        return '{rd: vecs[idx].rd, opr_a: vecs[idx].opr_a, opr_b: vecs[idx].opr_b,
                 opr_c: vecs[idx].opr_c, uop: vecs[idx].uop, fu: vecs[idx].fu,
                 trap: vecs[idx].trap, size: vecs[idx].size, instr: vecs[idx].instr};
    endfunction

    function automatic exec_pkg::ex_ctrl_t expect_ctrl(input int idx);
        return '{rd: vecs[idx].rd, uop: vecs[idx].exp_uop, fu: vecs[idx].fu,
                 trap: vecs[idx].trap, size: vecs[idx].size, instr: vecs[idx].instr};
    endfunction

    function automatic exec_pkg::fwd_t expect_fwd(input int idx);
        return '{rd: vecs[idx].rd, wdata: vecs[idx].exp_a,
                 load: vecs[idx].fu.lsu && !vecs[idx].uop[`EXEC_LSU_STORE],  // Load, not store
                 csr: vecs[idx].fu.csr};
    endfunction

    // Per-cycle drive and check ---
    task automatic drive_inputs();
        logic [31:0] r;
        r       = next_rand();
        i_flush = (vec_idx < n_vec) && (vec_idx % 10 == 9) && (flush_mark != vec_idx);
        if (i_flush) flush_mark = vec_idx;
        i_s3_busy  = i_flush || (r[18:16] < 3'd3);      // Flush drops the held entry
        i_s2_valid = (vec_idx < n_vec) && (i_flush || r[22:20] != 3'd0);
        if (vec_idx < n_vec) i_s2 = make_input(vec_idx);
        else i_s2 = '0;
    endtask

    task automatic check_outputs();
        s3_out_t e;
        compare_flag(o_s2_busy, (exp_q.size() != 0) && i_s3_busy, "o_s2_busy");
        compare_flag(o_s3_valid, exp_q.size() != 0, "o_s3_valid");
        if (vec_idx < n_vec) compare_fwd(o_fwd, expect_fwd(vec_idx), "o_fwd");
        if (exp_q.size() != 0) begin
            e = exp_q[0];                               // Held until taken
            compare_ctrl(o_s3_ctrl, e.ctrl, "o_s3_ctrl");
            compare_word(o_s3_opr_a, e.opr_a, "o_s3_opr_a");
            compare_word(o_s3_opr_b, e.opr_b, "o_s3_opr_b");
            if (!i_s3_busy) exp_q.delete(0);            // Taken downstream
        end
        if (i_flush) begin
            vec_idx = vec_idx - exp_q.size();           // Dropped entry is replayed
            exp_q.delete();
        end
        if (i_s2_valid && !o_s2_busy && !i_flush) begin
            if (vecs[vec_idx].b_ld) model_b = vecs[vec_idx].exp_b;
            e = '{ctrl: expect_ctrl(vec_idx), opr_a: vecs[vec_idx].exp_a, opr_b: model_b};
            exp_q.push_back(e);
            vec_idx = vec_idx + 1;
        end
    endtask

    initial begin
        g_resetn    = 1'b0;
        i_s2        = '0;
        i_s2_valid  = 1'b0;
        i_flush     = 1'b0;
        i_s3_busy   = 1'b0;
        lcg_state   = 32'd4;
        model_b     = '0;                       // B register value after reset
        vec_idx     = 0;
        flush_mark  = -1;
        cycles      = 0;
        cycle_limit = 100;
        load_vectors();
        cycle_limit = n_vec * 10 + 100;
        repeat (8) @(posedge g_clk);
        @(negedge g_clk);
        g_resetn = 1'b1;
        compare_flag(o_s3_valid, 1'b0, "o_s3_valid after reset");
        compare_ctrl(o_s3_ctrl, '0, "o_s3_ctrl after reset");
        compare_word(o_s3_opr_a, '0, "o_s3_opr_a after reset");
        compare_word(o_s3_opr_b, '0, "o_s3_opr_b after reset");
        while (vec_idx < n_vec || exp_q.size() != 0) begin
            drive_inputs();
            @(posedge g_clk);
            check_outputs();
            @(negedge g_clk);
        end
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: hdl/exec_stage.sv
/*
 * Execute stage top level
 * Connects the ALU, branch unit and result select to the control and
 * operand pipeline registers
 */
`timescale 1ns/1ns

module exec_stage (
    input  logic               g_clk,           // Global clock
    input  logic               g_resetn,        // Synchronous reset
    input  exec_pkg::ex_in_t   i_s2,            // Instruction from decode
    input  logic               i_s2_valid,      // Instruction valid
    input  logic               i_flush,         // Flush the stage
    input  logic               i_s3_busy,       // Next stage stalled
    output logic               o_s2_busy,       // Stage cannot accept
    output exec_pkg::ex_ctrl_t o_s3_ctrl,       // Registered control
    output exec_pkg::word_t    o_s3_opr_a,      // Registered operand A
    output exec_pkg::word_t    o_s3_opr_b,      // Registered operand B
    output logic               o_s3_valid,      // Output valid
    output exec_pkg::fwd_t     o_fwd            // Forwarding to decode
);

    exec_pkg::alu_out_t alu_out;
    exec_pkg::uop_t     cfu_uop;
    exec_pkg::word_t    cfu_target;
    exec_pkg::word_t    n_opr_a;
    exec_pkg::word_t    n_opr_b;
    exec_pkg::ex_ctrl_t n_ctrl;
    logic               ld_a;
    logic               ld_b;
    logic               s2_accept;

    assign s2_accept = i_s2_valid && !o_s2_busy && !i_flush;   // Instruction taken

    // Functional units -------------
    exec_alu u_alu (
        .i_opr_a (i_s2.opr_a), .i_opr_b (i_s2.opr_b), .i_uop (i_s2.uop),
        .i_sel   (i_s2.fu.alu), .o_alu  (alu_out)
    );

    exec_branch_unit u_branch (
        .i_uop   (i_s2.uop), .i_sel (i_s2.fu.cfu), .i_alu (alu_out),
        .i_opr_c (i_s2.opr_c), .o_uop (cfu_uop), .o_target (cfu_target)
    );

    exec_result_mux u_result_mux (
        .i_s2      (i_s2),      .i_alu        (alu_out),
        .i_cfu_uop (cfu_uop),   .i_cfu_target (cfu_target),
        .i_accept  (s2_accept), .o_opr_a      (n_opr_a),
        .o_opr_b   (n_opr_b),   .o_ld_a       (ld_a),
        .o_ld_b    (ld_b),      .o_ctrl       (n_ctrl),
        .o_fwd     (o_fwd)
    );

    // Pipeline registers -----------
    exec_pipe_reg #(.payload_t(exec_pkg::ex_ctrl_t)) ctrl_reg (
        .g_clk  (g_clk),      .g_resetn (g_resetn),  .i_flush (i_flush),
        .i_data (n_ctrl),     .i_valid  (i_s2_valid), .i_busy (i_s3_busy),
        .o_busy (o_s2_busy),  .o_data   (o_s3_ctrl), .o_valid (o_s3_valid)
    );

    exec_pipe_reg #(.payload_t(exec_pkg::word_t)) opr_a_reg (
        .g_clk  (g_clk),      .g_resetn (g_resetn),  .i_flush (i_flush),
        .i_data (n_opr_a),    .i_valid  (ld_a),      .i_busy  (i_s3_busy),
        .o_busy (),           .o_data   (o_s3_opr_a), .o_valid ()
    );

    exec_pipe_reg #(.payload_t(exec_pkg::word_t)) opr_b_reg (
        .g_clk  (g_clk),      .g_resetn (g_resetn),  .i_flush (i_flush),
        .i_data (n_opr_b),    .i_valid  (ld_b),      .i_busy  (i_s3_busy),
        .o_busy (),           .o_data   (o_s3_opr_b), .o_valid ()
    );

endmodule

// File: hdl/exec_pipe_reg.sv
/*
 * One-entry pipeline register
 * Holds a payload and its valid bit under a valid / busy handshake
 */
`timescale 1ns/1ns

module exec_pipe_reg #(
    parameter type payload_t = logic        // Carried payload
) (
    input  logic     g_clk,                 // Global clock
    input  logic     g_resetn,              // Synchronous reset
    input  logic     i_flush,               // Drop the held entry
    input  payload_t i_data,                // Data from this stage
    input  logic     i_valid,               // Data valid
    input  logic     i_busy,                // Next stage stalled
    output logic     o_busy,                // Cannot accept
    output payload_t o_data,                // Data to next stage
    output logic     o_valid                // Held entry valid
);

    logic load;
    logic take;

    assign o_busy = o_valid && i_busy;      // Back-pressure only
    assign load   = i_valid && !o_busy && !i_flush;
    assign take   = o_valid && !i_busy;     // Next stage consumes

    always_ff @(posedge g_clk) begin
        if (!g_resetn) begin
            o_valid <= 1'b0;
            o_data  <= '0;
        end else begin
            if (i_flush) begin
                o_valid <= 1'b0;            // Flush wins over everything
            end else if (load) begin
                o_valid <= 1'b1;
            end else if (take) begin
                o_valid <= 1'b0;
            end
            if (load) begin
                o_data <= i_data;           // Hold otherwise
            end
        end
    end

endmodule

// File: hdl/exec_result_mux.sv
/*
 * Result selection
 * Picks the next stage operands per unit, forms load enables,
 * the registered control and the forwarding bundle
 */
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_result_mux (
    input  exec_pkg::ex_in_t   i_s2,            // Incoming instruction
    input  exec_pkg::alu_out_t i_alu,           // ALU results
    input  exec_pkg::uop_t     i_cfu_uop,       // Resolved branch micro-op
    input  exec_pkg::word_t    i_cfu_target,    // Jump target
    input  logic               i_accept,        // Stage takes the instruction
    output exec_pkg::word_t    o_opr_a,         // Next operand A
    output exec_pkg::word_t    o_opr_b,         // Next operand B
    output logic               o_ld_a,          // Load operand A register
    output logic               o_ld_b,          // Load operand B register
    output exec_pkg::ex_ctrl_t o_ctrl,          // Next control
    output exec_pkg::fwd_t     o_fwd            // Forwarding bundle
);

    exec_pkg::fu_t fu;
    logic          store;

    assign fu    = i_s2.fu;
    assign store = fu.lsu && i_s2.uop[`EXEC_LSU_STORE];

    // Operand select ---------------
    assign o_opr_a = {`EXEC_XLEN{fu.alu}} & i_alu.result      |
                     {`EXEC_XLEN{fu.lsu}} & i_alu.add_result  |    // Address
                     {`EXEC_XLEN{fu.cfu}} & i_cfu_target      |
                     {`EXEC_XLEN{fu.csr}} & i_s2.opr_a;            // CSR address / data

    assign o_opr_b = {`EXEC_XLEN{fu.lsu || fu.csr}} & i_s2.opr_c;  // Store or CSR data

    assign o_ld_a = i_accept && (fu.alu || fu.lsu || fu.cfu || fu.csr);
    assign o_ld_b = i_accept && (store || fu.csr);      // B kept otherwise

    // Control ----------------------
    assign o_ctrl = '{
        rd    : i_s2.rd,
        uop   : fu.cfu ? i_cfu_uop : i_s2.uop,          // Resolved branch code
        fu    : fu,
        trap  : i_s2.trap,
        size  : i_s2.size,
        instr : i_s2.instr
    };

    // Forwarding -------------------
    assign o_fwd = '{
        rd    : i_s2.rd,
        wdata : o_opr_a,
        load  : fu.lsu && !store,                       // Data not yet known
        csr   : fu.csr
    };

endmodule

// File: hdl/exec_branch_unit.sv
/*
 * Control-flow unit
 * Resolves conditional branches to taken / not taken and forms jump targets
 */
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_branch_unit (
    input  exec_pkg::uop_t     i_uop,       // Micro-op code
    input  logic               i_sel,       // CFU is the selected unit
    input  exec_pkg::alu_out_t i_alu,       // Compare flags and adder
    input  exec_pkg::word_t    i_opr_c,     // Precomputed target
    output exec_pkg::uop_t     o_uop,       // Resolved micro-op
    output exec_pkg::word_t    o_target     // Jump target
);

    logic cond;
    logic taken;
    logic jalr;

    assign cond = i_sel && (i_uop[`EXEC_UOP_W-1 -: 2] == 2'b00);   // Conditional class
    assign jalr = i_sel && (i_uop == `EXEC_CFU_JALR);

    // The ALU compares A with B for every instruction
    always_comb begin
        case (i_uop)
            `EXEC_CFU_BEQ  : taken =  i_alu.eq;
            `EXEC_CFU_BNE  : taken = !i_alu.eq;
            `EXEC_CFU_BLT  : taken =  i_alu.lt_signed;
            `EXEC_CFU_BGE  : taken = !i_alu.lt_signed;
            `EXEC_CFU_BLTU : taken =  i_alu.lt_unsigned;
            `EXEC_CFU_BGEU : taken = !i_alu.lt_unsigned;
            default        : taken = 1'b0;
        endcase
    end

    assign o_uop = cond ? (taken ? `EXEC_CFU_TAKEN : `EXEC_CFU_NOT_TAKEN) :
                          i_uop;                    // Jumps pass through

    assign o_target = jalr ? {i_alu.add_result[`EXEC_XLEN-1:1], 1'b0} :    // rs1 + imm
                             {i_opr_c[`EXEC_XLEN-1:1], 1'b0};              // PC relative

endmodule

// File: hdl/exec_alu.sv
/*
 * Single-cycle ALU
 * Add, logic, shift, rotate and set-less-than, plus the shared adder
 * and compare flags used by the load/store and branch paths
 */
`timescale 1ns/1ns
`include "exec_config.svh"

module exec_alu (
    input  exec_pkg::word_t    i_opr_a,     // Left hand operand
    input  exec_pkg::word_t    i_opr_b,     // Right hand operand
    input  exec_pkg::uop_t     i_uop,       // Micro-op code
    input  logic               i_sel,       // ALU is the selected unit
    output exec_pkg::alu_out_t o_alu        // Result and flags
);

    exec_pkg::word_t           add_result;
    exec_pkg::word_t           sub_result;
    exec_pkg::word_t           result;
    logic [4:0]                shamt;
    logic [2*`EXEC_XLEN-1:0]   rot_wide;
    logic                      lt_signed;
    logic                      lt_unsigned;
    logic                      eq;

    // Shared arithmetic ------------
    assign add_result  = i_opr_a + i_opr_b;         // Also the LSU address
    assign sub_result  = i_opr_a - i_opr_b;
    assign lt_signed   = $signed(i_opr_a) < $signed(i_opr_b);
    assign lt_unsigned = i_opr_a < i_opr_b;
    assign eq          = i_opr_a == i_opr_b;

    assign shamt    = i_opr_b[4:0];                 // Low five bits only
    assign rot_wide = {i_opr_a, i_opr_a} >> shamt;  // Doubled word for rotate

    // Result select ----------------
    always_comb begin
        result = '0;                                // Idle unit gives zero
        if (i_sel) begin
            case (i_uop)
                `EXEC_ALU_ADD  : result = add_result;
                `EXEC_ALU_SUB  : result = sub_result;
                `EXEC_ALU_XOR  : result = i_opr_a ^ i_opr_b;
                `EXEC_ALU_OR   : result = i_opr_a | i_opr_b;
                `EXEC_ALU_AND  : result = i_opr_a & i_opr_b;
                `EXEC_ALU_SLL  : result = i_opr_a << shamt;
                `EXEC_ALU_SRL  : result = i_opr_a >> shamt;
                `EXEC_ALU_SRA  : result = exec_pkg::word_t'($signed(i_opr_a) >>> shamt);
                `EXEC_ALU_ROR  : result = rot_wide[`EXEC_XLEN-1:0];
                `EXEC_ALU_SLT  : result = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
                `EXEC_ALU_SLTU : result = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
                default        : result = '0;       // Unknown code
            endcase
        end
    end

    assign o_alu = '{
        result      : result,
        add_result  : add_result,
        lt_signed   : lt_signed,
        lt_unsigned : lt_unsigned,
        eq          : eq
    };

endmodule

// File: hdl/exec_pkg.sv
/*
 * Execute stage types
 * Words, micro-ops, unit select and the bundles passed between blocks
 */
`include "exec_config.svh"

package exec_pkg;

    typedef logic [`EXEC_XLEN-1:0]  word_t;     // One data word
    typedef logic [`EXEC_UOP_W-1:0] uop_t;      // One micro-op

    // One-hot functional unit select
    typedef struct packed {
        logic alu;                              // Arithmetic / logic
        logic lsu;                              // Load / store address
        logic cfu;                              // Branch and jump
        logic csr;                              // CSR pass-through
    } fu_t;

    // Instruction entering the stage ----
    typedef struct packed {
        logic [4:0]  rd;                        // Destination register
        word_t       opr_a;                     // Operand A
        word_t       opr_b;                     // Operand B
        word_t       opr_c;                     // Operand C
        uop_t        uop;                       // Micro-op code
        fu_t         fu;                        // Unit select
        logic        trap;                      // Raise a trap
        logic [1:0]  size;                      // Instruction size
        logic [31:0] instr;                     // Instruction word
    } ex_in_t;

    // Registered control for the next stage
    typedef struct packed {
        logic [4:0]  rd;
        uop_t        uop;                       // Resolved for branches
        fu_t         fu;
        logic        trap;
        logic [1:0]  size;
        logic [31:0] instr;
    } ex_ctrl_t;

    typedef struct packed {
        word_t result;                          // Selected ALU result
        word_t add_result;                      // A + B, always valid
        logic  lt_signed;                       // A < B signed
        logic  lt_unsigned;                     // A < B unsigned
        logic  eq;                              // A == B
    } alu_out_t;

    typedef struct packed {
        logic [4:0] rd;                         // Destination register
        word_t      wdata;                      // Value about to register
        logic       load;                       // Load in flight
        logic       csr;                        // CSR op in flight
    } fwd_t;

endpackage

// File: hdl/exec_config.svh
/*
 * Execute stage configuration
 * Data width, micro-op encodings and control-flow result codes
 */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// Widths ------------------------
`define EXEC_XLEN           32          // Data word width
`define EXEC_UOP_W          5           // Micro-op width

// ALU micro-ops -----------------
`define EXEC_ALU_ADD        5'b01_001   // Add
`define EXEC_ALU_SUB        5'b01_000   // Subtract
`define EXEC_ALU_XOR        5'b01_100   // Bitwise xor
`define EXEC_ALU_OR         5'b01_010   // Bitwise or
`define EXEC_ALU_AND        5'b01_110   // Bitwise and
`define EXEC_ALU_SLL        5'b10_001   // Shift left logical
`define EXEC_ALU_SRL        5'b10_010   // Shift right logical
`define EXEC_ALU_SRA        5'b10_100   // Shift right arithmetic
`define EXEC_ALU_ROR        5'b10_110   // Rotate right
`define EXEC_ALU_SLT        5'b00_001   // Set less than, signed
`define EXEC_ALU_SLTU       5'b00_010   // Set less than, unsigned

// Control-flow micro-ops --------
`define EXEC_CFU_BEQ        5'b00_001   // Conditional, top bits 00
`define EXEC_CFU_BGE        5'b00_010
`define EXEC_CFU_BGEU       5'b00_011
`define EXEC_CFU_BLT        5'b00_100
`define EXEC_CFU_BLTU       5'b00_101
`define EXEC_CFU_BNE        5'b00_110
`define EXEC_CFU_JALI       5'b10_001   // Unconditional, top bits 10
`define EXEC_CFU_JALR       5'b10_010
`define EXEC_CFU_JMP        5'b10_100
`define EXEC_CFU_TAKEN      5'b11_001   // Resolved branch, taken
`define EXEC_CFU_NOT_TAKEN  5'b11_000   // Resolved branch, not taken

`define EXEC_LSU_STORE      4           // Micro-op bit set for stores

`endif
